// ==== project.f ====
+incdir+hw
hw/rec_pkg.sv
hw/recovery_pec.sv
hw/recovery_receiver.sv
hw/recovery_executor.sv
hw/recovery_transmitter.sv
hw/recovery_regs.sv
hw/recovery_handler.sv
verification/tb_recovery_handler.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_recovery_handler -f project.f

status=0
./obj_dir/Vtb_recovery_handler > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== verification/tb_recovery_handler.sv ====
// Recovery handler testbench, directed packet, Wishbone and read response checks
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module tb_recovery_handler;

  // Generous bound over all directed tests
  localparam int CycleLimit = 20000;

  logic                 clk;
  logic                 rst;
  rec_pkg::rec_stream_t rx;
  rec_pkg::rec_stream_t tx;
  logic                 rx_ready;
  logic                 bus_start;
  logic                 bus_stop;
  logic                 tx_ready;
  rec_pkg::rec_wb_req_t wb_req;
  rec_pkg::rec_wb_rsp_t wb_rsp;

  // Reference model
  logic [31:0]          model [`REC_NUM_REGS];
  logic [31:0]          exp_errcnt;
  logic                 rec_on;
  rec_pkg::rec_byte_t   resp_bytes [7];
  int                   cycle_cnt = 0;

  recovery_handler dut_i (
    .clk_i      (clk),
    .rst_i      (rst),
    .rx_i       (rx),
    .rx_ready_o (rx_ready),
    .bus_start_i(bus_start),
    .bus_stop_i (bus_stop),
    .tx_o       (tx),
    .tx_ready_i (tx_ready),
    .wb_i       (wb_req),
    .wb_o       (wb_rsp)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Simulation timed out after %0d cycles", CycleLimit);
      $display("ERRORS FOUND");
      $fatal(1, "Run did not finish in time");
    end
  end

  // Serial CRC-8, one bit per step, MSB first
  function automatic rec_pkg::rec_byte_t crc8_update(input rec_pkg::rec_byte_t crc,
                                                     input rec_pkg::rec_byte_t data);
    rec_pkg::rec_byte_t r;
    logic               fb;
    r = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = r[7] ^ data[i];
      r = {r[6:0], 1'b0} ^ (fb ? `REC_PEC_POLY : 8'h00);
    end
    return r;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Word mismatch");
    end
  endtask

  task automatic check_byte(input string what, input rec_pkg::rec_byte_t got,
                            input rec_pkg::rec_byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Byte mismatch");
    end
  endtask

  // All stimulus changes 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic wb_write(input logic [`REC_WB_ADR_W-1:0] addr, input logic [31:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = addr;
    wb_req.dat = dat;
    next_cycle();
    while (!wb_rsp.ack) next_cycle();
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    next_cycle();
  endtask

  task automatic wb_read(input logic [`REC_WB_ADR_W-1:0] addr, output logic [31:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = addr;
    next_cycle();
    while (!wb_rsp.ack) next_cycle();
    dat = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    next_cycle();
  endtask

  task automatic set_mode(input logic [31:0] mode);
    wb_write(`REC_ADR_STATUS, mode);
    rec_on = (mode[7:0] == `REC_MODE_RECOVERY);
  endtask

  // Ready is a register output, so it is stable for the whole cycle
  task automatic push_byte(input rec_pkg::rec_byte_t b);
    rx.valid = 1'b1;
    rx.data  = b;
    while (!rx_ready) next_cycle();
    next_cycle();
    rx.valid = 1'b0;
  endtask

  task automatic pulse_start();
    bus_start = 1'b1;
    next_cycle();
    bus_start = 1'b0;
  endtask

  task automatic pulse_stop();
    bus_stop = 1'b1;
    next_cycle();
    bus_stop = 1'b0;
  endtask

  // Sends a write packet and applies the acceptance rule to the model
  task automatic send_write(input rec_pkg::rec_byte_t cmd, input logic [15:0] len,
                            input logic [31:0] data, input int npay, input logic bad_pec);
    rec_pkg::rec_byte_t pkt [12];
    rec_pkg::rec_byte_t crc;
    rec_pkg::rec_byte_t off;
    logic               ok;
    pkt[0] = cmd;
    pkt[1] = len[7:0];
    pkt[2] = len[15:8];
    for (int i = 0; i < npay; i++) begin
      pkt[3+i] = (i < 4) ? data[8*i +: 8] : 8'(8'hc0 + i);
    end
    crc = '0;
    pulse_start();
    for (int i = 0; i < 3 + npay; i++) begin
      crc = crc8_update(crc, pkt[i]);
      push_byte(pkt[i]);
    end
    push_byte(bad_pec ? ~crc : crc);
    pulse_stop();
    off = cmd - `REC_CMD_BASE;
    ok = !bad_pec && (off < 8'd8) && (len >= 16'd1) && (len <= 16'd4) && (npay == int'(len));
    if (rec_on && ok) begin
      for (int k = 0; k < int'(len); k++) begin
        model[off[2:0]][8*k +: 8] = data[8*k +: 8];
      end
    end else if (rec_on) begin
      exp_errcnt = exp_errcnt + 32'd1;
    end
    // Update lands 3 cycles after the stop
    idle(3);
  endtask

  // Start, command byte, then a repeated start and a stop
  task automatic send_read(input rec_pkg::rec_byte_t cmd);
    rec_pkg::rec_byte_t off;
    off = cmd - `REC_CMD_BASE;
    pulse_start();
    push_byte(cmd);
    pulse_start();
    pulse_stop();
    if (rec_on && !(off < 8'd8)) begin
      exp_errcnt = exp_errcnt + 32'd1;
    end
  endtask

  task automatic collect_resp();
    int n;
    n = 0;
    while (n < 7) begin
      tx_ready = 1'($urandom % 2);
      if (tx.valid && tx_ready) begin
        resp_bytes[n] = tx.data;
        n++;
      end
      next_cycle();
    end
    tx_ready = 1'b0;
  endtask

  task automatic check_response(input logic [2:0] idx);
    rec_pkg::rec_byte_t exp_bytes [7];
    rec_pkg::rec_byte_t crc;
    exp_bytes[0] = 8'd4;
    exp_bytes[1] = 8'd0;
    for (int k = 0; k < 4; k++) begin
      exp_bytes[2+k] = model[idx][8*k +: 8];
    end
    crc = '0;
    for (int k = 0; k < 6; k++) begin
      crc = crc8_update(crc, exp_bytes[k]);
    end
    exp_bytes[6] = crc;
    for (int k = 0; k < 7; k++) begin
      check_byte($sformatf("response byte %0d of reg %0d", k, idx), resp_bytes[k], exp_bytes[k]);
    end
  endtask

  task automatic check_state();
    logic [31:0] got;
    for (int i = 0; i < `REC_NUM_REGS; i++) begin
      wb_read(`REC_WB_ADR_W'(`REC_ADR_REG0 + i), got);
      check_word($sformatf("register %0d", i), got, model[i]);
    end
    wb_read(`REC_ADR_ERRCNT, got);
    check_word("ERR_COUNT", got, exp_errcnt);
  endtask

  task automatic test_reset_state();
    logic [31:0] got;
    wb_read(`REC_ADR_STATUS, got);
    check_word("DEVICE_STATUS after reset", got, 32'd0);
    wb_read(`REC_ADR_ERRCNT, got);
    check_word("ERR_COUNT after reset", got, 32'd0);
    repeat (5) begin
      check_word("tx valid after reset", 32'(tx.valid), 32'd0);
      check_word("rx ready after reset", 32'(rx_ready), 32'd1);
      next_cycle();
    end
    set_mode(32'd3);
    wb_read(`REC_ADR_STATUS, got);
    check_word("DEVICE_STATUS", got, 32'd3);
  endtask

  task automatic test_mode_off();
    set_mode(32'd0);
    send_write(8'h22, 16'd4, 32'hdeadbeef, 4, 1'b0);
    check_state();
  endtask

  task automatic test_valid_writes();
    logic [31:0] got;
    set_mode(32'd3);
    send_write(8'h23, 16'd4, 32'h11223344, 4, 1'b0);
    check_state();
    send_write(8'h23, 16'd2, 32'h0000aabb, 2, 1'b0);
    wb_read(`REC_WB_ADR_W'(`REC_ADR_REG0 + 1), got);
    check_word("register 1 after partial write", got, 32'h1122aabb);
    check_state();
  endtask

  task automatic test_rejected_packets();
    send_write(8'h24, 16'd4, 32'h0badf00d, 4, 1'b0);
    send_write(8'h24, 16'd4, 32'h55667788, 4, 1'b1);
    check_state();
    send_write(8'h2a, 16'd4, 32'h55667788, 4, 1'b0);
    check_state();
    send_write(8'h21, 16'd4, 32'h55667788, 4, 1'b0);
    check_state();
    send_write(8'h24, 16'd0, 32'h0, 0, 1'b0);
    check_state();
    send_write(8'h24, 16'd5, 32'h01020304, 5, 1'b0);
    check_state();
    // Invalid read counts an error and sends nothing
    send_read(8'h40);
    repeat (10) begin
      check_word("tx valid after invalid read", 32'(tx.valid), 32'd0);
      next_cycle();
    end
    check_state();
  endtask

  task automatic test_read_response();
    send_read(8'h23);
    collect_resp();
    check_response(3'd1);
  endtask

  task automatic test_random_traffic();
    logic [2:0]  idx;
    logic [15:0] len;
    logic [31:0] data;
    repeat (20) begin
      idx  = 3'($urandom % 8);
      len  = 16'(1 + $urandom % 4);
      data = $urandom;
      send_write(8'(`REC_CMD_BASE + idx), len, data, int'(len), 1'b0);
      send_read(8'(`REC_CMD_BASE + idx));
      collect_resp();
      check_response(idx);
    end
    check_state();
  endtask

  initial begin
    void'($urandom(32'h3ebca596));
    rst        = 1'b1;
    rx         = '0;
    bus_start  = 1'b0;
    bus_stop   = 1'b0;
    tx_ready   = 1'b0;
    wb_req     = '0;
    rec_on     = 1'b0;
    exp_errcnt = '0;
    for (int i = 0; i < `REC_NUM_REGS; i++) begin
      model[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    next_cycle();

    test_reset_state();
    test_mode_off();
    test_valid_writes();
    test_rejected_packets();
    test_read_response();
    test_random_traffic();

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/recovery_handler.sv ====
// Recovery handler top, connects receiver, executor, transmitter and register file
`timescale 1ns/1ps
`default_nettype none

module recovery_handler (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rec_pkg::rec_stream_t rx_i,
  output logic                 rx_ready_o,
  input  logic                 bus_start_i,
  input  logic                 bus_stop_i,
  output rec_pkg::rec_stream_t tx_o,
  input  logic                 tx_ready_i,
  input  rec_pkg::rec_wb_req_t wb_i,
  output rec_pkg::rec_wb_rsp_t wb_o
);

  logic               rec_enable;
  logic               cmd_valid;
  logic               cmd_ready;
  rec_pkg::rec_cmd_t  cmd;
  rec_pkg::rec_wr_t   wr;
  logic [2:0]         rd_idx;
  logic [31:0]        rd_data;
  rec_pkg::rec_resp_t resp;
  logic               resp_ready;
  logic               err_inc;

  // Packet parsing
  recovery_receiver xrecovery_receiver (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .enable_i   (rec_enable),
    .rx_i       (rx_i),
    .bus_start_i(bus_start_i),
    .bus_stop_i (bus_stop_i),
    .cmd_ready_i(cmd_ready),
    .rx_ready_o (rx_ready_o),
    .cmd_valid_o(cmd_valid),
    .cmd_o      (cmd)
  );

  recovery_executor xrecovery_executor (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .enable_i    (rec_enable),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .resp_ready_i(resp_ready),
    .rd_data_i   (rd_data),
    .cmd_ready_o (cmd_ready),
    .wr_o        (wr),
    .rd_idx_o    (rd_idx),
    .resp_o      (resp),
    .err_inc_o   (err_inc)
  );

  // Response path
  recovery_transmitter xrecovery_transmitter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .enable_i    (rec_enable),
    .resp_i      (resp),
    .tx_ready_i  (tx_ready_i),
    .resp_ready_o(resp_ready),
    .tx_o        (tx_o)
  );

  recovery_regs xrecovery_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wb_i        (wb_i),
    .wr_i        (wr),
    .rd_idx_i    (rd_idx),
    .err_inc_i   (err_inc),
    .wb_o        (wb_o),
    .rd_data_o   (rd_data),
    .rec_enable_o(rec_enable)
  );

endmodule

`default_nettype wire

// ==== hw/recovery_regs.sv ====
// Recovery register file, Wishbone classic slave for DEVICE_STATUS, ERR_COUNT and the registers
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module recovery_regs (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  rec_pkg::rec_wb_req_t wb_i,
  input  rec_pkg::rec_wr_t     wr_i,
  input  logic [2:0]           rd_idx_i,
  input  logic                 err_inc_i,
  output rec_pkg::rec_wb_rsp_t wb_o,
  output logic [31:0]          rd_data_o,
  output logic                 rec_enable_o
);

  logic [31:0]              status_q;
  logic [31:0]              errcnt_q;
  logic [31:0]              regs_q [`REC_NUM_REGS];
  logic                     ack_q;
  logic [31:0]              rdat_q;
  logic [31:0]              rdat_d;
  logic                     wb_req;
  logic                     wb_wr;
  logic [`REC_WB_ADR_W-1:0] reg_off;
  logic                     adr_is_reg;
  logic                     wb_reg_we;

  // Ack goes high once, one cycle after the request is seen
  assign wb_req = wb_i.cyc && wb_i.stb && !ack_q;
  assign wb_wr = wb_req && wb_i.we;

  // STATUS and ERRCNT wrap to large offsets here
  assign reg_off = wb_i.adr - `REC_ADR_REG0;
  assign adr_is_reg = reg_off < `REC_WB_ADR_W'(`REC_NUM_REGS);

  // Executor takes the register on a same-cycle clash
  assign wb_reg_we = wb_wr && adr_is_reg && !(wr_i.valid && (wr_i.idx == reg_off[2:0]));

  always_comb begin
    case (wb_i.adr)
      `REC_ADR_STATUS: rdat_d = status_q;
      `REC_ADR_ERRCNT: rdat_d = errcnt_q;
      default:         rdat_d = adr_is_reg ? regs_q[reg_off[2:0]] : '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      status_q <= '0;
      errcnt_q <= '0;
      ack_q    <= 1'b0;
      for (int r = 0; r < `REC_NUM_REGS; r++) begin
        regs_q[r] <= '0;
      end
    end else begin
      ack_q <= wb_req;
      // ERR_COUNT is read only
      if (wb_wr && (wb_i.adr == `REC_ADR_STATUS)) begin
        status_q <= wb_i.dat;
      end
      if (err_inc_i) begin
        errcnt_q <= errcnt_q + 32'd1;
      end
      if (wb_reg_we) begin
        regs_q[reg_off[2:0]] <= wb_i.dat;
      end
      if (wr_i.valid) begin
        for (int b = 0; b < `REC_REG_BYTES; b++) begin
          if (wr_i.be[b]) begin
            regs_q[wr_i.idx][8*b +: 8] <= wr_i.data[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      rdat_q <= rdat_d;
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rdat_q;
  assign rd_data_o = regs_q[rd_idx_i];
  assign rec_enable_o = (status_q[7:0] == `REC_MODE_RECOVERY);

endmodule

`default_nettype wire

// ==== hw/recovery_transmitter.sv ====
// Recovery transmitter, sends length, register bytes and PEC of a read response
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module recovery_transmitter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 enable_i,
  input  rec_pkg::rec_resp_t   resp_i,
  input  logic                 tx_ready_i,
  output logic                 resp_ready_o,
  output rec_pkg::rec_stream_t tx_o
);

  // Two length bytes, the data bytes, then the PEC
  localparam logic [2:0] LastIdx = 3'(`REC_REG_BYTES + 2);

  logic               busy_q;
  logic [2:0]         cnt_q;
  logic [31:0]        data_q;
  logic [1:0]         lane;
  logic               accept;
  logic               tx_fire;
  rec_pkg::rec_byte_t byte_d;
  rec_pkg::rec_byte_t crc;

  assign resp_ready_o = enable_i && !busy_q;
  assign accept = resp_i.valid && resp_ready_o;
  assign tx_fire = busy_q && tx_ready_i;
  assign lane = 2'(cnt_q - 3'd2);

  // Byte select, stable while the counter waits for ready
  always_comb begin
    case (cnt_q)
      3'd0:    byte_d = 8'(`REC_REG_BYTES);
      3'd1:    byte_d = '0;
      LastIdx: byte_d = crc;
      default: byte_d = data_q[8*lane +: 8];
    endcase
  end

  recovery_pec xtx_pec (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(accept || !enable_i),
    .en_i   (tx_fire && (cnt_q != LastIdx)),
    .data_i (byte_d),
    .crc_o  (crc)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i || !enable_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (tx_fire) begin
      if (cnt_q == LastIdx) begin
        busy_q <= 1'b0;
      end
      cnt_q <= cnt_q + 3'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      data_q <= resp_i.data;
    end
  end

  assign tx_o.valid = busy_q;
  assign tx_o.data = byte_d;

endmodule

`default_nettype wire

// ==== hw/recovery_executor.sv ====
// Recovery executor, validates commands, commits writes, starts read responses, counts errors
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module recovery_executor (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               enable_i,
  input  logic               cmd_valid_i,
  input  rec_pkg::rec_cmd_t  cmd_i,
  input  logic               resp_ready_i,
  input  logic [31:0]        rd_data_i,
  output logic               cmd_ready_o,
  output rec_pkg::rec_wr_t   wr_o,
  output logic [2:0]         rd_idx_o,
  output rec_pkg::rec_resp_t resp_o,
  output logic               err_inc_o
);

  rec_pkg::rec_byte_t cmd_off;
  logic               in_range;
  logic               len_ok;
  logic               wr_ok;
  logic [4:0]         be_full;
  logic               accept;
  logic               wr_vld_q;
  logic [2:0]         idx_q;
  logic [31:0]        wr_data_q;
  logic [3:0]         be_q;
  logic               fetch_q;
  logic               resp_vld_q;
  logic [31:0]        resp_data_q;
  logic               err_q;

  // No new command while a read is still in flight
  assign cmd_ready_o = enable_i && !fetch_q && !resp_vld_q;
  assign accept = cmd_valid_i && cmd_ready_o;

  // Codes below the base wrap around and fall out of range
  assign cmd_off = cmd_i.cmd - `REC_CMD_BASE;
  assign in_range = cmd_off < 8'(`REC_NUM_REGS);
  assign len_ok = (cmd_i.len >= 16'd1) && (cmd_i.len <= 16'(`REC_REG_BYTES)) &&
                  (16'(cmd_i.pay_cnt) == cmd_i.len);
  assign wr_ok = cmd_i.pec_ok && in_range && len_ok;

  // Lanes 0 .. len-1
  assign be_full = (5'd1 << cmd_i.len[2:0]) - 5'd1;

  always_ff @(posedge clk_i) begin
    if (rst_i || !enable_i) begin
      wr_vld_q   <= 1'b0;
      fetch_q    <= 1'b0;
      resp_vld_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      wr_vld_q <= accept && !cmd_i.is_rd && wr_ok;
      fetch_q  <= accept && cmd_i.is_rd && in_range;
      err_q    <= accept && !(cmd_i.is_rd ? in_range : wr_ok);
      if (fetch_q) begin
        resp_vld_q <= 1'b1;
      end else if (resp_vld_q && resp_ready_i) begin
        resp_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_q     <= cmd_off[2:0];
      wr_data_q <= cmd_i.data;
      be_q      <= be_full[3:0];
    end
    // Register read returns in the cycle after accept
    if (fetch_q) begin
      resp_data_q <= rd_data_i;
    end
  end

  assign wr_o.valid = wr_vld_q;
  assign wr_o.idx = idx_q;
  assign wr_o.data = wr_data_q;
  assign wr_o.be = be_q;
  assign rd_idx_o = idx_q;
  assign resp_o.valid = resp_vld_q;
  assign resp_o.data = resp_data_q;
  assign err_inc_o = err_q;

endmodule

`default_nettype wire

// ==== hw/recovery_receiver.sv ====
// Recovery receiver, parses framed packets from the byte stream and checks their PEC
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module recovery_receiver (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 enable_i,
  input  rec_pkg::rec_stream_t rx_i,
  input  logic                 bus_start_i,
  input  logic                 bus_stop_i,
  input  logic                 cmd_ready_i,
  output logic                 rx_ready_o,
  output logic                 cmd_valid_o,
  output rec_pkg::rec_cmd_t    cmd_o
);

  localparam logic [2:0] MaxPay = 3'(`REC_REG_BYTES);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_LEN_L,
    ST_LEN_H,
    ST_DATA
  } state_e;

  state_e             state_q;
  rec_pkg::rec_byte_t cmd_byte_q;
  logic [15:0]        len_q;
  logic [31:0]        pay_q;
  logic [2:0]         pay_cnt_q;
  rec_pkg::rec_byte_t held_q;
  logic               held_vld_q;
  logic               cmd_valid_q;
  rec_pkg::rec_cmd_t  cmd_q;
  rec_pkg::rec_byte_t pec_data;
  rec_pkg::rec_byte_t crc;
  logic               rx_fire;
  logic               pec_en;
  logic               emit_wr;
  logic               emit_rd;

  // Bus conditions take priority over a byte in the same cycle
  assign rx_ready_o = !cmd_valid_q;
  assign rx_fire = rx_i.valid && rx_ready_o && !bus_start_i && !bus_stop_i;
  assign emit_wr = bus_stop_i && (state_q == ST_DATA);
  // Repeated start right after the command byte is a read request
  assign emit_rd = bus_start_i && !bus_stop_i && (state_q == ST_LEN_L);

  // The last data byte may be the PEC, so it is only folded once the next one arrives
  assign pec_data = (state_q == ST_DATA) ? held_q : rx_i.data;
  assign pec_en = rx_fire && ((state_q == ST_CMD) || (state_q == ST_LEN_L) ||
                              (state_q == ST_LEN_H) || (state_q == ST_DATA && held_vld_q));

  recovery_pec xrx_pec (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .clear_i(bus_start_i || !enable_i),
    .en_i   (pec_en),
    .data_i (pec_data),
    .crc_o  (crc)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i || !enable_i) begin
      state_q     <= ST_IDLE;
      held_vld_q  <= 1'b0;
      pay_cnt_q   <= '0;
      cmd_valid_q <= 1'b0;
    end else begin
      if (cmd_valid_q && cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end
      if (emit_wr || emit_rd) begin
        cmd_valid_q <= 1'b1;
      end
      if (bus_stop_i) begin
        state_q <= ST_IDLE;
      end else if (bus_start_i) begin
        state_q    <= ST_CMD;
        held_vld_q <= 1'b0;
        pay_cnt_q  <= '0;
      end else if (rx_fire) begin
        case (state_q)
          ST_CMD:   state_q <= ST_LEN_L;
          ST_LEN_L: state_q <= ST_LEN_H;
          ST_LEN_H: state_q <= ST_DATA;
          ST_DATA: begin
            held_vld_q <= 1'b1;
            // Saturate one past the register width
            if (held_vld_q && pay_cnt_q <= MaxPay) begin
              pay_cnt_q <= pay_cnt_q + 3'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Field staging
  always_ff @(posedge clk_i) begin
    if (rx_fire) begin
      case (state_q)
        ST_CMD:   cmd_byte_q <= rx_i.data;
        ST_LEN_L: len_q[7:0] <= rx_i.data;
        ST_LEN_H: len_q[15:8] <= rx_i.data;
        ST_DATA: begin
          held_q <= rx_i.data;
          if (held_vld_q && pay_cnt_q < MaxPay) begin
            pay_q[8*pay_cnt_q[1:0] +: 8] <= held_q;
          end
        end
        default: ;
      endcase
    end
    if (emit_wr) begin
      cmd_q.cmd     <= cmd_byte_q;
      cmd_q.is_rd   <= 1'b0;
      cmd_q.len     <= len_q;
      cmd_q.data    <= pay_q;
      cmd_q.pay_cnt <= pay_cnt_q;
      cmd_q.pec_ok  <= held_vld_q && (held_q == crc);
    end else if (emit_rd) begin
      // A read request carries no PEC
      cmd_q.cmd     <= cmd_byte_q;
      cmd_q.is_rd   <= 1'b1;
      cmd_q.len     <= '0;
      cmd_q.data    <= '0;
      cmd_q.pay_cnt <= '0;
      cmd_q.pec_ok  <= 1'b0;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o = cmd_q;

endmodule

`default_nettype wire

// ==== hw/recovery_pec.sv ====
// Recovery PEC, running CRC-8 over the bytes it is handed
`timescale 1ns/1ps
`default_nettype none

`include "rec_defines.svh"

module recovery_pec (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               clear_i,
  input  logic               en_i,
  input  rec_pkg::rec_byte_t data_i,
  output rec_pkg::rec_byte_t crc_o
);

  rec_pkg::rec_byte_t crc_q;

  // MSB first, one byte per call
  function automatic rec_pkg::rec_byte_t crc_fold(input rec_pkg::rec_byte_t crc,
                                                  input rec_pkg::rec_byte_t data);
    rec_pkg::rec_byte_t c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      c = c[7] ? ((c << 1) ^ `REC_PEC_POLY) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_q <= '0;
    end else if (en_i) begin
      crc_q <= crc_fold(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

endmodule

`default_nettype wire

// ==== hw/rec_pkg.sv ====
// Recovery handler types shared by the byte streams, the command path and Wishbone
`default_nettype none

`include "rec_defines.svh"

package rec_pkg;

  typedef logic [7:0] rec_byte_t;

  // Ready travels back as its own signal
  typedef struct packed {
    logic      valid;
    rec_byte_t data;
  } rec_stream_t;

  // Parsed packet, pay_cnt saturates at REC_REG_BYTES+1
  typedef struct packed {
    rec_byte_t   cmd;
    logic        is_rd;
    logic [15:0] len;
    logic [31:0] data;
    logic [2:0]  pay_cnt;
    logic        pec_ok;
  } rec_cmd_t;

  typedef struct packed {
    logic        valid;
    logic [2:0]  idx;
    logic [31:0] data;
    logic [3:0]  be;
  } rec_wr_t;

  // Length of a response is always REC_REG_BYTES
  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } rec_resp_t;

  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`REC_WB_ADR_W-1:0] adr;
    logic [31:0]              dat;
  } rec_wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } rec_wb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/rec_defines.svh ====
// Recovery handler constants: mode value, command range, sizes and Wishbone word map
`ifndef REC_DEFINES_SVH
`define REC_DEFINES_SVH

// DEVICE_STATUS[7:0] value that turns recovery on
`define REC_MODE_RECOVERY 8'd3

// Commands REC_CMD_BASE .. REC_CMD_BASE+7 map onto the registers
`define REC_CMD_BASE 8'h22
`define REC_NUM_REGS 8
`define REC_REG_BYTES 4

// CRC-8 polynomial of the PEC
`define REC_PEC_POLY 8'h07

// Wishbone word addresses
`define REC_WB_ADR_W 4
`define REC_ADR_STATUS 4'd0
`define REC_ADR_ERRCNT 4'd1
`define REC_ADR_REG0 4'd2

`endif
